// ==== rtl/mm_pkg.sv ====
// Matrix-multiply accelerator shared definitions
// Array geometry, element and accumulator types, memory port structs
`default_nettype none

package mm_pkg;

    // Array geometry and element width
    localparam int SA_WIDTH = 4;
    localparam int DW       = 8;
    localparam int MEM_DW   = SA_WIDTH * DW;

    typedef logic signed [DW-1:0]                      elem_t;
    typedef logic signed [2*DW:0]                      accum_t;
    // All accumulators, row-major, element (0,0) in the low bits
    typedef logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0]     accum_mat_t;

    typedef logic [31:0]       mem_addr_t;
    typedef logic [MEM_DW-1:0] mem_data_t;
    typedef logic [7:0]        mat_dim_t;

    typedef struct packed {
        mem_addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        mem_addr_t addr;
        mem_data_t data;
    } mem_wr_req_t;

    typedef struct packed {
        mem_addr_t a_addr;
        mem_addr_t b_addr;
        mem_addr_t c_addr;
        mat_dim_t  width;
    } mm_cfg_t;

endpackage

`default_nettype wire

// ==== rtl/mat_buffer.sv ====
// Operand buffer
// One write port, one read port with registered output
`timescale 1ns/10ps
`default_nettype none

module mat_buffer #(
    parameter int BUF_AW = 6
) (
    input  wire                    clk,
    input  wire                    wr_en_i,
    input  wire [BUF_AW-1:0]       wr_addr_i,
    input  wire mm_pkg::mem_data_t wr_data_i,
    input  wire [BUF_AW-1:0]       rd_addr_i,
    output mm_pkg::mem_data_t      rd_data_o
);
    import mm_pkg::*;

    // One column of A or one row of B per word
    mem_data_t mem [2**BUF_AW];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== rtl/systolic_pe.sv ====
// Systolic array processing element
// Signed multiply-accumulate, forwards A to the right and B downward
`timescale 1ns/10ps
`default_nettype none

module systolic_pe (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 clear_i,
    input  wire mm_pkg::elem_t  a_i,
    input  wire mm_pkg::elem_t  b_i,
    input  wire                 valid_i,
    output mm_pkg::elem_t       a_o,
    output mm_pkg::elem_t       b_o,
    output logic                valid_o,
    output mm_pkg::accum_t      acc_o
);
    import mm_pkg::*;

    accum_t prod;

    // Operands are sign-extended to accumulator width first
    assign prod = a_i * b_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            acc_o   <= '0;
        end else begin
            valid_o <= valid_i;
            if (clear_i) begin
                acc_o <= '0;
            end else if (valid_i) begin
                acc_o <= acc_o + prod;
            end
        end
    end

    always_ff @(posedge clk) begin
        a_o <= a_i;
        b_o <= b_i;
    end

endmodule

`default_nettype wire

// ==== rtl/dma_engine.sv ====
// DMA engine for the matrix-multiply accelerator
// Fetches A and B into the operand buffers, starts the matrix engine,
// then writes the 16 accumulators of C back to memory
`timescale 1ns/10ps
`default_nettype none

module dma_engine #(
    parameter int BUF_AW = 6
) (
    input  wire                       clk,
    input  wire                       rst_n,

    // Configuration and control
    input  wire mm_pkg::mm_cfg_t      cfg_i,
    input  wire                       start_i,
    output logic                      done_o,

    // Memory read request and response
    output mm_pkg::mem_rd_req_t       rd_req_o,
    output logic                      rd_valid_o,
    input  wire                       rd_ready_i,
    input  wire mm_pkg::mem_data_t    rd_data_i,
    input  wire                       rd_rvalid_i,

    // Memory write
    output mm_pkg::mem_wr_req_t       wr_req_o,
    output logic                      wr_valid_o,
    input  wire                       wr_ready_i,

    // Operand buffer write port
    output logic                      buf_a_wren_o,
    output logic                      buf_b_wren_o,
    output logic [BUF_AW-1:0]         buf_waddr_o,
    output mm_pkg::mem_data_t         buf_wdata_o,

    // Matrix engine handshake
    output logic                      mm_start_o,
    input  wire                       mm_done_i,
    input  wire mm_pkg::accum_mat_t   accum_i
);
    import mm_pkg::*;

    // Room for 2K requests at the deepest buffer
    localparam int CNT_W  = BUF_AW + 2;
    localparam int ACC_W  = $bits(accum_t);
    localparam int N_ELEM = SA_WIDTH * SA_WIDTH;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        START_MM,
        WAIT_MM,
        WRITE_C
    } state_t;

    state_t                    state;
    logic [CNT_W-1:0]          req_cnt;
    logic [CNT_W-1:0]          rsp_cnt;
    logic [CNT_W-1:0]          total_req;
    logic [$clog2(N_ELEM)-1:0] elem_cnt;
    accum_t                    c_elem;

    // A and B words interleave, so 2K reads in total
    assign total_req = CNT_W'({cfg_i.width, 1'b0});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            req_cnt    <= '0;
            rsp_cnt    <= '0;
            elem_cnt   <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state   <= FETCH;
                        req_cnt <= '0;
                        rsp_cnt <= '0;
                    end
                end
                FETCH: begin
                    if (rd_valid_o && rd_ready_i) begin
                        req_cnt <= req_cnt + 1'b1;
                    end
                    if (rd_rvalid_i) begin
                        rsp_cnt <= rsp_cnt + 1'b1;
                        // Last response, its buffer write lands next cycle
                        if (rsp_cnt == total_req - 1'b1) begin
                            state <= START_MM;
                        end
                    end
                end
                START_MM: begin
                    mm_start_o <= 1'b1;
                    state      <= WAIT_MM;
                end
                WAIT_MM: begin
                    if (mm_done_i) begin
                        state    <= WRITE_C;
                        elem_cnt <= '0;
                    end
                end
                WRITE_C: begin
                    if (wr_ready_i) begin
                        elem_cnt <= elem_cnt + 1'b1;
                        if (elem_cnt == N_ELEM - 1) begin
                            state  <= IDLE;
                            done_o <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Read requests, even count from A, odd count from B
    assign rd_valid_o = (state == FETCH) && (req_cnt < total_req);

    always_comb begin
        rd_req_o.addr = (req_cnt[0] ? cfg_i.b_addr : cfg_i.a_addr)
                      + mem_addr_t'({req_cnt[CNT_W-1:1], 2'b00});
    end

    // Response parity picks the buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
        end else begin
            buf_a_wren_o <= (state == FETCH) && rd_rvalid_i && !rsp_cnt[0];
            buf_b_wren_o <= (state == FETCH) && rd_rvalid_i && rsp_cnt[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_rvalid_i) begin
            buf_waddr_o <= rsp_cnt[BUF_AW:1];
            buf_wdata_o <= rd_data_i;
        end
    end

    // C write-back, one sign-extended accumulator per word
    assign wr_valid_o = (state == WRITE_C);
    assign c_elem     = accum_i[elem_cnt*ACC_W +: ACC_W];

    always_comb begin
        wr_req_o.addr = cfg_i.c_addr + mem_addr_t'({elem_cnt, 2'b00});
        wr_req_o.data = {{(MEM_DW-ACC_W){c_elem[ACC_W-1]}}, c_elem};
    end

endmodule

`default_nettype wire

// ==== rtl/mm_engine.sv ====
// Matrix engine
// Streams the operand buffers with skew through a 4x4 output-stationary
// systolic array and pulses done when the last cell has accumulated
`timescale 1ns/10ps
`default_nettype none

module mm_engine #(
    parameter int BUF_AW = 6
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start_i,
    input  wire mm_pkg::mat_dim_t   width_i,
    output logic                    done_o,
    output logic [BUF_AW-1:0]       buf_raddr_o,
    input  wire mm_pkg::mem_data_t  buf_a_data_i,
    input  wire mm_pkg::mem_data_t  buf_b_data_i,
    output wire mm_pkg::accum_mat_t accum_o
);
    import mm_pkg::*;

    localparam int ACC_W      = $bits(accum_t);
    // Skew on both edges of the array before the last cell sees its data
    localparam int DRAIN_LAST = 2 * (SA_WIDTH - 1);

    logic                           rd_active;
    logic [BUF_AW-1:0]              rd_cnt;
    logic                           feed_vld;
    logic                           drain_on;
    logic [$clog2(DRAIN_LAST+1)-1:0] drain_cnt;

    // Operand grids between cells, index 0 is the array edge
    elem_t a_grid [SA_WIDTH][SA_WIDTH+1];
    elem_t b_grid [SA_WIDTH+1][SA_WIDTH];
    logic  v_grid [SA_WIDTH][SA_WIDTH+1];

    assign buf_raddr_o = rd_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_cnt    <= '0;
            feed_vld  <= 1'b0;
            drain_on  <= 1'b0;
            drain_cnt <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o   <= 1'b0;
            // Buffer data follows its address by one cycle
            feed_vld <= rd_active;
            if (start_i) begin
                rd_active <= 1'b1;
                rd_cnt    <= '0;
            end else if (rd_active) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (mat_dim_t'(rd_cnt) == width_i - mat_dim_t'(1)) begin
                    rd_active <= 1'b0;
                    drain_on  <= 1'b1;
                    drain_cnt <= '0;
                end
            end
            if (drain_on) begin
                drain_cnt <= drain_cnt + 1'b1;
                if (drain_cnt == DRAIN_LAST) begin
                    drain_on <= 1'b0;
                    done_o   <= 1'b1;
                end
            end
        end
    end

    // Lane i delays row i of A and column i of B by i cycles
    for (genvar i = 0; i < SA_WIDTH; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign a_grid[i][0] = buf_a_data_i[i*DW +: DW];
            assign b_grid[0][i] = buf_b_data_i[i*DW +: DW];
            assign v_grid[i][0] = feed_vld;
        end else begin : g_skew
            elem_t a_dly   [i];
            elem_t b_dly   [i];
            logic  vld_dly [i];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < i; s++) begin
                        vld_dly[s] <= 1'b0;
                    end
                end else begin
                    vld_dly[0] <= feed_vld;
                    for (int s = 1; s < i; s++) begin
                        vld_dly[s] <= vld_dly[s-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                a_dly[0] <= buf_a_data_i[i*DW +: DW];
                b_dly[0] <= buf_b_data_i[i*DW +: DW];
                for (int s = 1; s < i; s++) begin
                    a_dly[s] <= a_dly[s-1];
                    b_dly[s] <= b_dly[s-1];
                end
            end

            assign a_grid[i][0] = a_dly[i-1];
            assign b_grid[0][i] = b_dly[i-1];
            assign v_grid[i][0] = vld_dly[i-1];
        end
    end

    // PE grid, valid travels right together with A
    for (genvar i = 0; i < SA_WIDTH; i++) begin : g_row
        for (genvar j = 0; j < SA_WIDTH; j++) begin : g_col
            systolic_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .clear_i (start_i),
                .a_i     (a_grid[i][j]),
                .b_i     (b_grid[i][j]),
                .valid_i (v_grid[i][j]),
                .a_o     (a_grid[i][j+1]),
                .b_o     (b_grid[i+1][j]),
                .valid_o (v_grid[i][j+1]),
                .acc_o   (accum_o[(i*SA_WIDTH+j)*ACC_W +: ACC_W])
            );
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mm_accel_top.sv ====
// Matrix-multiply accelerator top level
// DMA engine, A and B operand buffers and the systolic matrix engine
`timescale 1ns/10ps
`default_nettype none

module mm_accel_top #(
    parameter int BUF_AW = 6
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire mm_pkg::mm_cfg_t    cfg_i,
    input  wire                     start_i,
    output wire                     done_o,
    output wire mm_pkg::mem_rd_req_t rd_req_o,
    output wire                     rd_valid_o,
    input  wire                     rd_ready_i,
    input  wire mm_pkg::mem_data_t  rd_data_i,
    input  wire                     rd_rvalid_i,
    output wire mm_pkg::mem_wr_req_t wr_req_o,
    output wire                     wr_valid_o,
    input  wire                     wr_ready_i
);
    import mm_pkg::*;

    wire              buf_a_wren;
    wire              buf_b_wren;
    wire [BUF_AW-1:0] buf_waddr;
    mem_data_t        buf_wdata;
    wire [BUF_AW-1:0] buf_raddr;
    mem_data_t        buf_a_rdata;
    mem_data_t        buf_b_rdata;
    wire              mm_start;
    wire              mm_done;
    accum_mat_t       accum;

    dma_engine #(.BUF_AW(BUF_AW)) u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_i        (cfg_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .rd_req_o     (rd_req_o),
        .rd_valid_o   (rd_valid_o),
        .rd_ready_i   (rd_ready_i),
        .rd_data_i    (rd_data_i),
        .rd_rvalid_i  (rd_rvalid_i),
        .wr_req_o     (wr_req_o),
        .wr_valid_o   (wr_valid_o),
        .wr_ready_i   (wr_ready_i),
        .buf_a_wren_o (buf_a_wren),
        .buf_b_wren_o (buf_b_wren),
        .buf_waddr_o  (buf_waddr),
        .buf_wdata_o  (buf_wdata),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    mat_buffer #(.BUF_AW(BUF_AW)) u_buf_a (
        .clk       (clk),
        .wr_en_i   (buf_a_wren),
        .wr_addr_i (buf_waddr),
        .wr_data_i (buf_wdata),
        .rd_addr_i (buf_raddr),
        .rd_data_o (buf_a_rdata)
    );

    mat_buffer #(.BUF_AW(BUF_AW)) u_buf_b (
        .clk       (clk),
        .wr_en_i   (buf_b_wren),
        .wr_addr_i (buf_waddr),
        .wr_data_i (buf_wdata),
        .rd_addr_i (buf_raddr),
        .rd_data_o (buf_b_rdata)
    );

    mm_engine #(.BUF_AW(BUF_AW)) u_mm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (mm_start),
        .width_i      (cfg_i.width),
        .done_o       (mm_done),
        .buf_raddr_o  (buf_raddr),
        .buf_a_data_i (buf_a_rdata),
        .buf_b_data_i (buf_b_rdata),
        .accum_o      (accum)
    );

endmodule

`default_nettype wire

// ==== sim/tb_mm_accel.sv ====
// Testbench for the matrix-multiply accelerator
// Memory model with random read latency and ready, directed matrix tests
`timescale 1ns/10ps
`default_nettype none

module tb_mm_accel;
    import mm_pkg::*;

    localparam int MAX_K = 64;
    localparam int N_C   = SA_WIDTH * SA_WIDTH;
    // Sum of (2K+40)*8 over all runs
    localparam int WATCHDOG_CYC = 8 * ((2*4 + 40) + 2 * (2*16 + 40) + (2*1 + 40)
                                       + (2*64 + 40) + 2 * (2*8 + 40));

    logic        clk;
    logic        rst_n;
    mm_cfg_t     cfg;
    logic        start;
    logic        done;
    mem_rd_req_t rd_req;
    logic        rd_valid;
    logic        rd_ready;
    mem_data_t   rd_data;
    logic        rd_rvalid;
    mem_wr_req_t wr_req;
    logic        wr_valid;
    logic        wr_ready;

    // Memory model state, keyed by word address
    mem_data_t   mem [mem_addr_t];
    mem_data_t   rsp_data [$];
    int          rsp_due [$];
    mem_addr_t   wr_log [$];
    logic [31:0] mem_rng = 32'h8c13fd00;
    logic [31:0] data_rng = 32'h8c13fd00;
    logic        rand_ready;
    int          cyc;
    int          rd_cnt;
    int          done_cnt;

    elem_t       a_mat [SA_WIDTH][MAX_K];
    elem_t       b_mat [MAX_K][SA_WIDTH];

    mm_accel_top #(.BUF_AW(6)) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_i       (cfg),
        .start_i     (start),
        .done_o      (done),
        .rd_req_o    (rd_req),
        .rd_valid_o  (rd_valid),
        .rd_ready_i  (rd_ready),
        .rd_data_i   (rd_data),
        .rd_rvalid_i (rd_rvalid),
        .wr_req_o    (wr_req),
        .wr_valid_o  (wr_valid),
        .wr_ready_i  (wr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_data();
        data_rng = xorshift32(data_rng);
        return data_rng;
    endfunction

    // Unwritten words hold a pattern unique to their address
    function automatic mem_data_t read_word(input mem_addr_t addr);
        if (mem.exists(addr >> 2)) begin
            return mem[addr >> 2];
        end
        return mem_data_t'(addr ^ 32'ha5c3_0f96);
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_data_t got, input mem_data_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input mat_dim_t got, input mat_dim_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Handshakes sampled mid-cycle, responses and ready driven after the edge
    initial begin : memory_model
        logic        rd_fire;
        logic        wr_fire;
        mem_addr_t   rd_addr;
        mem_wr_req_t wr_cap;
        rd_ready  = 1'b1;
        wr_ready  = 1'b1;
        rd_rvalid = 1'b0;
        rd_data   = '0;
        forever begin
            @(negedge clk);
            rd_fire = rd_valid && rd_ready;
            wr_fire = wr_valid && wr_ready;
            rd_addr = rd_req.addr;
            wr_cap  = wr_req;
            if (rd_fire) begin
                rd_cnt++;
            end
            if (done) begin
                done_cnt++;
            end
            @(posedge clk);
            #1;
            cyc++;
            if (rd_fire) begin
                mem_rng = xorshift32(mem_rng);
                rsp_data.push_back(read_word(rd_addr));
                rsp_due.push_back(cyc + 1 + int'(mem_rng[1:0]));
            end
            if (wr_fire) begin
                mem[wr_cap.addr >> 2] = wr_cap.data;
                wr_log.push_back(wr_cap.addr);
            end
            // In order, at most one response per cycle
            if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
                rd_rvalid = 1'b1;
                rd_data   = rsp_data.pop_front();
                void'(rsp_due.pop_front());
            end else begin
                rd_rvalid = 1'b0;
                rd_data   = '0;
            end
            mem_rng  = xorshift32(mem_rng);
            rd_ready = rand_ready ? mem_rng[3] : 1'b1;
            wr_ready = rand_ready ? mem_rng[9] : 1'b1;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        fail_stop("Timeout: the tests did not finish within the expected number of cycles");
    end

    task automatic fill_random(input int k);
        for (int kk = 0; kk < k; kk++) begin
            for (int i = 0; i < SA_WIDTH; i++) begin
                a_mat[i][kk] = elem_t'(next_data());
                b_mat[kk][i] = elem_t'(next_data());
            end
        end
    endtask

    // Load operands, run one multiply and check C against the reference sums
    task automatic run_matmul(input mat_dim_t k, input mem_addr_t a_addr,
                              input mem_addr_t b_addr, input mem_addr_t c_addr,
                              input bit extra_start);
        int        sum;
        accum_t    acc;
        mem_data_t word;
        mem_data_t exp_c [N_C];
        for (int kk = 0; kk < k; kk++) begin
            for (int i = 0; i < SA_WIDTH; i++) begin
                word[i*DW +: DW] = a_mat[i][kk];
            end
            mem[(a_addr >> 2) + kk] = word;
            for (int j = 0; j < SA_WIDTH; j++) begin
                word[j*DW +: DW] = b_mat[kk][j];
            end
            mem[(b_addr >> 2) + kk] = word;
        end
        for (int e = 0; e < N_C; e++) begin
            sum = 0;
            for (int kk = 0; kk < k; kk++) begin
                sum += int'(a_mat[e / SA_WIDTH][kk]) * int'(b_mat[kk][e % SA_WIDTH]);
            end
            // The sum wraps at accumulator width, then sign-extends
            acc      = accum_t'(sum);
            exp_c[e] = mem_data_t'(int'(acc));
            mem.delete((c_addr >> 2) + e);
        end
        rd_cnt   = 0;
        done_cnt = 0;
        wr_log.delete();
        cfg   = '{a_addr: a_addr, b_addr: b_addr, c_addr: c_addr, width: k};
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (extra_start) begin
            repeat (10) @(posedge clk);
            #1;
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        wait (done_cnt != 0);
        repeat (20) @(posedge clk);
        #1;
        check_count("done_o pulse count", mat_dim_t'(done_cnt), 8'd1);
        check_count("rd_valid_o transfer count", mat_dim_t'(rd_cnt), mat_dim_t'(2 * k));
        check_count("wr_valid_o transfer count", mat_dim_t'(wr_log.size()), mat_dim_t'(N_C));
        for (int e = 0; e < N_C; e++) begin
            check_word($sformatf("c_word[%0d][%0d]", e / SA_WIDTH, e % SA_WIDTH),
                       read_word(c_addr + mem_addr_t'(4 * e)), exp_c[e]);
        end
    endtask

    task automatic identity_test();
        for (int kk = 0; kk < 4; kk++) begin
            for (int i = 0; i < SA_WIDTH; i++) begin
                a_mat[i][kk] = (i == kk) ? 8'sd1 : 8'sd0;
                b_mat[kk][i] = elem_t'(4 * kk + i + 1);
            end
        end
        run_matmul(8'd4, 32'h1000, 32'h1400, 32'h1800, 1'b0);
    endtask

    // Operands reused by the random ready test
    task automatic random_signed_test();
        fill_random(16);
        a_mat[0][0] = -8'sd128;
        b_mat[0][0] = -8'sd128;
        a_mat[2][7] = -8'sd128;
        b_mat[7][3] = -8'sd128;
        b_mat[7][1] = 8'sd127;
        run_matmul(8'd16, 32'h2000, 32'h2400, 32'h2800, 1'b0);
    endtask

    task automatic random_ready_test();
        @(negedge clk);
        rand_ready = 1'b1;
        @(posedge clk);
        #1;
        run_matmul(8'd16, 32'h3000, 32'h3400, 32'h3800, 1'b0);
        @(negedge clk);
        rand_ready = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic edge_width_test();
        fill_random(1);
        run_matmul(8'd1, 32'h4000, 32'h4100, 32'h4200, 1'b0);
        fill_random(MAX_K);
        run_matmul(8'd64, 32'h5000, 32'h5400, 32'h5800, 1'b0);
    endtask

    task automatic back_to_back_test();
        fill_random(8);
        run_matmul(8'd8, 32'h6000, 32'h6100, 32'h6200, 1'b1);
        fill_random(8);
        run_matmul(8'd8, 32'h6000, 32'h6100, 32'h6200, 1'b0);
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        cfg        = '0;
        rand_ready = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        identity_test();
        random_signed_test();
        random_ready_test();
        edge_width_test();
        back_to_back_test();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/mm_pkg.sv
rtl/mat_buffer.sv
rtl/systolic_pe.sv
rtl/dma_engine.sv
rtl/mm_engine.sv
rtl/mm_accel_top.sv
sim/tb_mm_accel.sv
